/* include/cube_defines.svh */
// Geometry of the 8x8x8 cube is fixed; the controller sequencing assumes these exact values
`ifndef CUBE_DEFINES_SVH
`define CUBE_DEFINES_SVH

// ======================================================================
// Cube geometry
// ======================================================================

`define CUBE_LAYERS      8   // Layers, written top layer first
`define CUBE_DEPTH       64  // Column positions per layer
`define CUBE_ADDR_W      6   // Word address width, log2 of CUBE_DEPTH

// ======================================================================
// Memory word and configuration
// ======================================================================

`define CUBE_WORD_BYTES  4   // Tag, red, green, blue
`define CUBE_CONF_BYTES  4   // Configuration register bytes

`endif

/* verilog/cube_pkg.sv */
// Types shared by the cube front end; sizes come from the defines header and are not tunable
`default_nettype none

`include "cube_defines.svh"

package cube_pkg;

    // Command opcodes, sent with the data/command line low
    typedef enum logic [7:0] {
        CMD_CONF_WR = 8'h2a,
        CMD_ADDR_WR = 8'h2b,
        CMD_DATA_WR = 8'h2c
    } cube_cmd_e;

    typedef logic [`CUBE_ADDR_W-1:0] cube_addr_t;

    // Byte 3 tag, byte 2 red, byte 1 green, byte 0 blue
    typedef logic [`CUBE_WORD_BYTES*8-1:0] cube_word_t;

    typedef logic [$clog2(`CUBE_LAYERS)-1:0] cube_layer_sel_t;

endpackage

`default_nettype wire

/* verilog/spi_byte_rx.sv */
// SPI mode 0, write only, MSB first; sclk must stay below about a quarter of clk_in
`timescale 1ns/1ps
`default_nettype none

module spi_byte_rx (
    input  logic       clk_in,
    input  logic       rst_n_in,
    input  logic       spi_cs_n,
    input  logic       spi_sclk,
    input  logic       spi_mosi,
    input  logic       spi_dc,
    output logic       byte_rdy,
    output logic [7:0] byte_data,
    output logic       byte_dc
);

    logic [1:0] cs_sync;
    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic [1:0] dc_sync;
    logic       sclk_d;
    logic       bit_take;
    logic [2:0] bit_cnt;
    logic [6:0] shift_q;

    assign bit_take = sclk_sync[1] & ~sclk_d & ~cs_sync[1];   // Rising sclk inside a frame

    // ==================================================================
    // Pin synchronizers and bit counter
    // ==================================================================

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            cs_sync   <= 2'b11;
            sclk_sync <= 2'b00;
            mosi_sync <= 2'b00;
            dc_sync   <= 2'b00;
            sclk_d    <= 1'b0;
            bit_cnt   <= '0;
            byte_rdy  <= 1'b0;
        end else begin
            cs_sync   <= {cs_sync[0], spi_cs_n};
            sclk_sync <= {sclk_sync[0], spi_sclk};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            dc_sync   <= {dc_sync[0], spi_dc};
            sclk_d    <= sclk_sync[1];
            byte_rdy  <= bit_take && (bit_cnt == 3'd7);
            if (cs_sync[1]) begin
                bit_cnt <= '0;   // A partial byte is dropped here
            end else if (bit_take) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (bit_take) begin
            shift_q <= {shift_q[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                byte_data <= {shift_q, mosi_sync[1]};
                byte_dc   <= dc_sync[1];
            end
        end
    end

    a_rdy_single: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        byte_rdy |=> !byte_rdy);

endmodule

`default_nettype wire

/* verilog/layer_ctrl.sv */
// Unknown commands drop the write mode; bytes past the end of a sequence are ignored
`timescale 1ns/1ps
`default_nettype none

`include "cube_defines.svh"

module layer_ctrl
    import cube_pkg::*;
(
    input  logic                  clk_in,
    input  logic                  rst_n_in,
    input  logic                  dc,
    input  logic                  byte_rdy,
    input  logic [7:0]            byte_data,
    output logic [`CUBE_LAYERS:0] wr_en,
    output logic                  wr_done,
    output cube_addr_t            wr_addr,
    output logic [3:0]            wr_byte_en
);

    logic                     conf_wr;
    logic [`CUBE_LAYERS-1:0]  code_wr;   // One-hot in data mode, all ones in address mode
    logic                     addr_en;
    logic [2:0]               data_en;   // Red, green, blue in turn
    logic                     data_rdy;
    logic                     conf_done;
    logic                     addr_done;
    logic                     data_done;

    assign data_rdy  = byte_rdy & dc;
    assign conf_done = (wr_addr == cube_addr_t'(`CUBE_CONF_BYTES - 1));
    assign addr_done = (wr_addr == cube_addr_t'(`CUBE_DEPTH - 1));
    assign data_done = data_en[0];

    // ==================================================================
    // Write strobes
    // ==================================================================

    assign wr_en      = {`CUBE_LAYERS+1{data_rdy}} & {conf_wr, code_wr};
    assign wr_done    = data_rdy & code_wr[0] & addr_done & data_done;   // Last blue of layer 0
    assign wr_byte_en = {addr_en, data_en};

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            conf_wr <= 1'b0;
            code_wr <= '0;
            addr_en <= 1'b0;
            data_en <= 3'b000;
            wr_addr <= '0;
        end else if (byte_rdy && !dc) begin
            conf_wr <= 1'b0;
            code_wr <= '0;
            addr_en <= 1'b0;
            data_en <= 3'b000;
            wr_addr <= '0;
            case (cube_cmd_e'(byte_data))
                CMD_CONF_WR: begin
                    conf_wr <= 1'b1;
                end
                CMD_ADDR_WR: begin
                    code_wr <= '1;   // Tags are broadcast to every layer
                    addr_en <= 1'b1;
                end
                CMD_DATA_WR: begin
                    code_wr <= {1'b1, {(`CUBE_LAYERS-1){1'b0}}};
                    data_en <= 3'b100;
                end
                default: ;
            endcase
        end else if (data_rdy) begin
            if (conf_wr) begin
                conf_wr <= !conf_done;
                wr_addr <= wr_addr + cube_addr_t'(1);
            end
            if (addr_en) begin
                if (addr_done) begin
                    addr_en <= 1'b0;
                    code_wr <= '0;
                end
                wr_addr <= wr_addr + cube_addr_t'(1);
            end
            if (data_en != 3'b000) begin
                data_en <= {data_en[0], data_en[2:1]};
                if (data_done) begin
                    wr_addr <= wr_addr + cube_addr_t'(1);   // Wraps to 0 at layer end
                    if (addr_done) begin
                        code_wr <= code_wr >> 1;
                        if (code_wr[0]) data_en <= 3'b000;
                    end
                end
            end
        end
    end

    a_layer_code: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        $onehot0(wr_en[`CUBE_LAYERS-1:0]) || (&wr_en[`CUBE_LAYERS-1:0]));

    a_conf_alone: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        wr_en[`CUBE_LAYERS] |-> !(|wr_en[`CUBE_LAYERS-1:0]));

endmodule

`default_nettype wire

/* verilog/layer_ram.sv */
// No reset, contents are undefined until written; read data lags the address by one cycle
`timescale 1ns/1ps
`default_nettype none

`include "cube_defines.svh"

module layer_ram
    import cube_pkg::*;
(
    input  logic                        clk_in,
    input  logic                        wr_en,
    input  logic [`CUBE_WORD_BYTES-1:0] wr_byte_en,
    input  cube_addr_t                  wr_addr,
    input  logic [7:0]                  wr_byte,
    input  cube_addr_t                  rd_addr,
    output cube_word_t                  rd_data
);

    cube_word_t mem [`CUBE_DEPTH];

    // Same byte goes to every lane, the enables pick the lane
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < `CUBE_WORD_BYTES; i++) begin
            if (wr_en && wr_byte_en[i]) begin
                mem[wr_addr][i*8 +: 8] <= wr_byte;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* verilog/frame_store.sv */
// Single frame buffer; the scanner reads while the host writes with no tearing protection
`timescale 1ns/1ps
`default_nettype none

`include "cube_defines.svh"

module frame_store
    import cube_pkg::*;
(
    input  logic                          clk_in,
    input  logic                          rst_n_in,
    input  logic [`CUBE_LAYERS:0]         wr_en,
    input  cube_addr_t                    wr_addr,
    input  logic [`CUBE_WORD_BYTES-1:0]   wr_byte_en,
    input  logic [7:0]                    wr_byte,
    input  cube_layer_sel_t               rd_layer,
    input  cube_addr_t                    rd_addr,
    output cube_word_t                    rd_data,
    output logic [`CUBE_CONF_BYTES*8-1:0] conf_data
);

    localparam int CONF_AW = $clog2(`CUBE_CONF_BYTES);

    cube_word_t      layer_q [`CUBE_LAYERS];
    cube_layer_sel_t rd_layer_q;

    // ==================================================================
    // Layer memories
    // ==================================================================

    for (genvar l = 0; l < `CUBE_LAYERS; l++) begin : g_layer
        layer_ram u_ram (
            .clk_in     (clk_in),
            .wr_en      (wr_en[l]),
            .wr_byte_en (wr_byte_en),
            .wr_addr    (wr_addr),
            .wr_byte    (wr_byte),
            .rd_addr    (rd_addr),
            .rd_data    (layer_q[l])
        );
    end

    // Layer select is delayed to line up with the registered RAM word
    always_ff @(posedge clk_in) begin
        rd_layer_q <= rd_layer;
    end

    assign rd_data = layer_q[rd_layer_q];

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            conf_data <= '0;
        end else if (wr_en[`CUBE_LAYERS]) begin
            conf_data[wr_addr[CONF_AW-1:0]*8 +: 8] <= wr_byte;   // Byte n lands in bits 8n+7..8n
        end
    end

endmodule

`default_nettype wire

/* verilog/cube_ctrl_top.sv */
// Command front end only; scanning, PWM and readback are outside this block
`timescale 1ns/1ps
`default_nettype none

`include "cube_defines.svh"

module cube_ctrl_top
    import cube_pkg::*;
(
    input  logic                          clk_in,
    input  logic                          rst_n_in,
    input  logic                          spi_cs_n,
    input  logic                          spi_sclk,
    input  logic                          spi_mosi,
    input  logic                          spi_dc,
    input  cube_layer_sel_t               rd_layer,
    input  cube_addr_t                    rd_addr,
    output cube_word_t                    rd_data,
    output logic [`CUBE_CONF_BYTES*8-1:0] conf_data,
    output logic                          frame_done
);

    logic                        byte_rdy;
    logic [7:0]                  byte_data;
    logic                        byte_dc;
    logic [`CUBE_LAYERS:0]       wr_en;
    cube_addr_t                  wr_addr;
    logic [`CUBE_WORD_BYTES-1:0] wr_byte_en;

    spi_byte_rx u_rx (
        .clk_in    (clk_in),
        .rst_n_in  (rst_n_in),
        .spi_cs_n  (spi_cs_n),
        .spi_sclk  (spi_sclk),
        .spi_mosi  (spi_mosi),
        .spi_dc    (spi_dc),
        .byte_rdy  (byte_rdy),
        .byte_data (byte_data),
        .byte_dc   (byte_dc)
    );

    layer_ctrl u_ctrl (
        .clk_in     (clk_in),
        .rst_n_in   (rst_n_in),
        .dc         (byte_dc),
        .byte_rdy   (byte_rdy),
        .byte_data  (byte_data),
        .wr_en      (wr_en),
        .wr_done    (frame_done),   // Pulses on the last byte of a full frame
        .wr_addr    (wr_addr),
        .wr_byte_en (wr_byte_en)
    );

    frame_store u_store (
        .clk_in     (clk_in),
        .rst_n_in   (rst_n_in),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_byte_en (wr_byte_en),
        .wr_byte    (byte_data),
        .rd_layer   (rd_layer),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .conf_data  (conf_data)
    );

endmodule

`default_nettype wire

/* verif/cube_ctrl_tests.svh */
// Tests run in order and share frame_model; later tests rely on tags and colours written earlier

// ======================================================================
// Configuration and tag writes
// ======================================================================

task automatic test_conf_write();
    begin_test("conf_write");
    send_cmd(CMD_CONF_WR);
    for (int i = 1; i <= 6; i++) begin
        send_data(8'(i * 17));   // 11, 22 .. 66; the last two fall past the register bank
    end
    settle_writes();
    check_conf("conf_data", 32'h4433_2211, conf_data);
    end_test();
endtask

task automatic test_addr_broadcast();
    cube_word_t word;
    begin_test("addr_broadcast");
    send_cmd(CMD_ADDR_WR);
    for (int a = 0; a < `CUBE_DEPTH; a++) begin
        send_data(8'(a) ^ 8'h5a);
        for (int l = 0; l < `CUBE_LAYERS; l++) begin
            frame_model[l][a][31:24] = 8'(a) ^ 8'h5a;
        end
    end
    settle_writes();
    for (int l = 0; l < `CUBE_LAYERS; l++) begin
        for (int a = 0; a < `CUBE_DEPTH; a += 9) begin
            read_word(cube_layer_sel_t'(l), cube_addr_t'(a), word);
            check_word($sformatf("tag layer %0d addr %0d", l, a),
                       frame_model[l][a] & 32'hff00_0000, word & 32'hff00_0000);
        end
    end
    end_test();
endtask

// ======================================================================
// Frame data
// ======================================================================

task automatic test_full_frame();
    logic [7:0] value;
    int         layer;
    int         addr;
    int         fd_base;
    cube_word_t word;
    begin_test("full_frame");
    fd_base = frame_done_seen;
    send_cmd(CMD_DATA_WR);
    for (int k = 0; k < 1536; k++) begin
        value = 8'($random(seed));
        layer = 7 - k / 192;           // 192 bytes per layer, top layer first
        addr  = (k % 192) / 3;
        frame_model[layer][addr][(2 - k % 3) * 8 +: 8] = value;   // Red, green, blue
        if (k == 1535) begin
            settle_writes();
            check_bit("frame_done before last byte", 1'b0, frame_done_seen != fd_base);
        end
        send_data(value);
    end
    settle_writes();
    check_bit("frame_done once", 1'b1, (frame_done_seen - fd_base) == 1);
    for (int l = 0; l < `CUBE_LAYERS; l++) begin
        for (int a = 0; a < `CUBE_DEPTH; a++) begin
            read_word(cube_layer_sel_t'(l), cube_addr_t'(a), word);
            check_word($sformatf("layer %0d addr %0d", l, a), frame_model[l][a], word);
        end
    end
    end_test();
endtask

task automatic test_restart_ignore();
    cube_word_t word;
    int         fd_base;
    begin_test("restart_ignore");
    fd_base = frame_done_seen;
    send_cmd(CMD_DATA_WR);   // Opens a data write that the unknown command has to cancel
    send_cmd(8'h55);   // Not an opcode
    for (int i = 0; i < 3; i++) begin
        send_data(8'he0 + 8'(i));
    end
    settle_writes();
    read_word(cube_layer_sel_t'(7), cube_addr_t'(0), word);
    check_word("layer 7 addr 0 after unknown command", frame_model[7][0], word);
    read_word(cube_layer_sel_t'(0), cube_addr_t'(63), word);
    check_word("layer 0 addr 63 after unknown command", frame_model[0][63], word);
    check_conf("conf after unknown command", 32'h4433_2211, conf_data);
    send_cmd(CMD_DATA_WR);
    for (int i = 0; i < 3; i++) begin
        send_data(8'hc0 + 8'(i));
    end
    send_cmd(CMD_DATA_WR);
    for (int i = 0; i < 3; i++) begin
        send_data(8'hd0 + 8'(i));
    end
    frame_model[7][0][23:0] = {8'hd0, 8'hd1, 8'hd2};
    settle_writes();
    read_word(cube_layer_sel_t'(7), cube_addr_t'(0), word);
    check_word("layer 7 addr 0 second triple", frame_model[7][0], word);
    read_word(cube_layer_sel_t'(7), cube_addr_t'(1), word);
    check_word("layer 7 addr 1 unchanged", frame_model[7][1], word);
    check_bit("no frame_done", 1'b0, frame_done_seen != fd_base);
    end_test();
endtask

task automatic test_partial_byte();
    begin_test("partial_byte");
    spi_send_bits(8'hff, 1'b1, 5);
    send_cmd(CMD_CONF_WR);
    for (int i = 0; i < 4; i++) begin
        send_data(8'ha1 + 8'(i));
    end
    settle_writes();
    check_conf("conf_data", 32'ha4a3_a2a1, conf_data);
    end_test();
endtask

/* verif/cube_ctrl_tb.sv */
// Directed tests only; the SPI driver uses a fixed bit rate of 4 clk_in cycles per bit
`timescale 1ns/1ps
`default_nettype none

`include "cube_defines.svh"

module cube_ctrl_tb
    import cube_pkg::*;
();

    localparam int TOTAL_BYTES     = 7 + 65 + 1537 + 13 + 6;   // Bytes sent over all tests
    localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 40 + 5000;

    logic                          clk_in = 1'b0;
    logic                          rst_n_in;
    logic                          spi_cs_n;
    logic                          spi_sclk;
    logic                          spi_mosi;
    logic                          spi_dc;
    cube_layer_sel_t               rd_layer;
    cube_addr_t                    rd_addr;
    cube_word_t                    rd_data;
    logic [`CUBE_CONF_BYTES*8-1:0] conf_data;
    logic                          frame_done;

    string      test_name;
    int         test_errors     = 0;
    int         error_count     = 0;
    int         check_count     = 0;
    int         tests_run       = 0;
    int         tests_failed    = 0;
    int         frame_done_seen = 0;
    integer     seed            = 32'h5a8b;
    cube_word_t frame_model [`CUBE_LAYERS][`CUBE_DEPTH];   // Expected contents of every layer

    always #50 clk_in = ~clk_in;

    cube_ctrl_top u_cube_ctrl_top (
        .clk_in     (clk_in),
        .rst_n_in   (rst_n_in),
        .spi_cs_n   (spi_cs_n),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .spi_dc     (spi_dc),
        .rd_layer   (rd_layer),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .conf_data  (conf_data),
        .frame_done (frame_done)
    );

    // frame_done is combinational from the strobe, so it is counted mid-cycle
    always @(negedge clk_in) begin
        if (frame_done === 1'b1) begin
            frame_done_seen++;
        end
    end

    // ==================================================================
    // SPI driver and read port
    // ==================================================================

    task automatic spi_send_bits(input logic [7:0] value, input logic dc, input int nbits);
        @(posedge clk_in);
        spi_cs_n <= 1'b0;
        spi_dc   <= dc;
        for (int i = 7; i > 7 - nbits; i--) begin
            spi_mosi <= value[i];   // MSB first, stable before the rising sclk
            spi_sclk <= 1'b0;
            repeat (2) @(posedge clk_in);
            spi_sclk <= 1'b1;
            repeat (2) @(posedge clk_in);
        end
        spi_sclk <= 1'b0;
        spi_cs_n <= 1'b1;
        @(posedge clk_in);
    endtask

    task automatic spi_send_byte(input logic [7:0] value, input logic dc);
        spi_send_bits(value, dc, 8);
    endtask

    task automatic send_cmd(input logic [7:0] code);
        spi_send_byte(code, 1'b0);
    endtask

    task automatic send_data(input logic [7:0] value);
        spi_send_byte(value, 1'b1);
    endtask

    // Lets the last byte pass the synchronizers and reach the frame store
    task automatic settle_writes();
        repeat (8) @(posedge clk_in);
        @(negedge clk_in);
    endtask

    task automatic read_word(input cube_layer_sel_t layer, input cube_addr_t addr,
                             output cube_word_t data);
        @(posedge clk_in);
        rd_layer <= layer;
        rd_addr  <= addr;
        repeat (2) @(posedge clk_in);
        @(negedge clk_in);
        data = rd_data;
    endtask

    // ==================================================================
    // Compare tasks and test bookkeeping
    // ==================================================================

    task automatic check_word(input string what, input cube_word_t expected,
                              input cube_word_t actual);
        check_count++;
        if (actual !== expected) begin
            test_errors++;
            $display("Error %s %s: expected %08h actual %08h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_conf(input string what, input logic [`CUBE_CONF_BYTES*8-1:0] expected,
                              input logic [`CUBE_CONF_BYTES*8-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            test_errors++;
            $display("Error %s %s: expected %08h actual %08h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            test_errors++;
            $display("Error %s %s: expected %0b actual %0b", test_name, what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        error_count += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
            $display("%-16s fail, %0d mismatches", test_name, test_errors);
        end else begin
            $display("%-16s ok", test_name);
        end
    endtask

    `include "cube_ctrl_tests.svh"

    initial begin
        rst_n_in <= 1'b0;
        spi_cs_n <= 1'b1;
        spi_sclk <= 1'b0;
        spi_mosi <= 1'b0;
        spi_dc   <= 1'b0;
        rd_layer <= '0;
        rd_addr  <= '0;
        repeat (16) @(posedge clk_in);
        rst_n_in <= 1'b1;
        repeat (4) @(posedge clk_in);
        test_conf_write();
        test_addr_broadcast();
        test_full_frame();
        test_restart_ignore();
        test_partial_byte();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
+incdir+verif
verilog/cube_pkg.sv
verilog/spi_byte_rx.sv
verilog/layer_ctrl.sv
verilog/layer_ram.sv
verilog/frame_store.sv
verilog/cube_ctrl_top.sv
verif/cube_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the cube front end testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/cube_ctrl_sim

verilator --binary --timing --assert -f vlog.f --top-module cube_ctrl_tb -o cube_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
